/* logic/exec_config.svh */
// ----------------------------------------------------------------------
// integer execution cluster parameters
// widths and depths shared by the pipes and the writeback unit
// ----------------------------------------------------------------------

`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// operand and result width
`define XLEN 32

// physical integer register file entries
`define PRF_INT_SIZE 64

// reorder buffer entries, one tag per slot
`define ROB_SIZE 32

// ALU results parked while mul owns the port
`define WB_SKID_DEPTH 2

// multiplier latency in cycles
`define MUL_STAGES 3

`endif

/* logic/exec_pkg.sv */
// ----------------------------------------------------------------------
// integer execution cluster types
// operand vectors, op encodings and the issue / result records
// ----------------------------------------------------------------------

`default_nettype none

`include "exec_config.svh"

package exec_pkg;

  typedef logic [`XLEN-1:0]                  word_t;
  typedef logic [$clog2(`PRF_INT_SIZE)-1:0] prf_index_t;
  typedef logic [$clog2(`ROB_SIZE)-1:0]     rob_tag_t;

  typedef enum logic [0:0] {
    FU_ALU,
    FU_MUL
  } fu_class_e;

  // ALU ops first, then the multiplier ops
  typedef enum logic [3:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_MUL, OP_MULH, OP_MULHU
  } int_op_e;

  // micro-op as it leaves register read
  typedef struct packed {
    fu_class_e  fu;
    int_op_e    op;
    rob_tag_t   tag;
    prf_index_t rd_index;
    logic       rd_valid;
    word_t      rs1_data;
    word_t      rs2_data;
  } issue_uop_t;

  // completed result for register file and ROB
  typedef struct packed {
    rob_tag_t   tag;
    prf_index_t rd_index;
    logic       rd_valid;
    word_t      data;
  } exec_result_t;

endpackage

`default_nettype wire

/* logic/alu_pipe.sv */
// ----------------------------------------------------------------------
// ALU execution pipe
// single-cycle integer operations with a registered result
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module alu_pipe import exec_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         flush,
  input  logic         uop_valid,
  input  issue_uop_t   uop,
  output logic         alu_valid,
  output exec_result_t alu_result
);

  logic                       accept;
  logic [$clog2(`XLEN)-1:0]   shamt;
  word_t                      alu_out;

  assign accept = uop_valid && (uop.fu == FU_ALU);

  // shift amount from the low bits of rs2
  assign shamt = uop.rs2_data[$clog2(`XLEN)-1:0];

  always_comb begin
    case (uop.op)
      OP_ADD:  alu_out = uop.rs1_data + uop.rs2_data;
      OP_SUB:  alu_out = uop.rs1_data - uop.rs2_data;
      OP_AND:  alu_out = uop.rs1_data & uop.rs2_data;
      OP_OR:   alu_out = uop.rs1_data | uop.rs2_data;
      OP_XOR:  alu_out = uop.rs1_data ^ uop.rs2_data;
      OP_SLL:  alu_out = uop.rs1_data << shamt;
      OP_SRL:  alu_out = uop.rs1_data >> shamt;
      // arithmetic shift keeps the sign bit
      OP_SRA:  alu_out = word_t'($signed(uop.rs1_data) >>> shamt);
      OP_SLT:  alu_out = word_t'($signed(uop.rs1_data) < $signed(uop.rs2_data));
      OP_SLTU: alu_out = word_t'(uop.rs1_data < uop.rs2_data);
      // mul ops never reach here
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      alu_valid <= 1'b0;
    end else begin
      alu_valid <= accept;
    end
  end

  // payload follows the accepted uop
  always_ff @(posedge clock) begin
    if (accept) begin
      alu_result.tag      <= uop.tag;
      alu_result.rd_index <= uop.rd_index;
      alu_result.rd_valid <= uop.rd_valid;
      alu_result.data     <= alu_out;
    end
  end

endmodule

`default_nettype wire

/* logic/mul_pipe.sv */
// ----------------------------------------------------------------------
// pipelined integer multiplier
// 33x33 signed product over three stages, low or high word out
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module mul_pipe import exec_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         flush,
  input  logic         uop_valid,
  input  issue_uop_t   uop,
  output logic         mul_valid,
  output exec_result_t mul_result
);

  localparam int last   = `MUL_STAGES - 1;
  localparam int ext_w  = `XLEN + 1;
  localparam int half_w = `XLEN / 2;
  localparam int pp_w   = ext_w + half_w + 1;

  logic                     accept;
  logic                     sign_ext;
  logic signed [ext_w-1:0]  a_ext;
  logic signed [ext_w-1:0]  b_ext;
  logic signed [pp_w-1:0]   pp_lo;
  logic signed [pp_w-1:0]   pp_hi;
  logic signed [pp_w-1:0]   s1_pp_lo;
  logic signed [pp_w-1:0]   s1_pp_hi;
  logic signed [2*ext_w-1:0] s2_prod;
  word_t                    s3_data;

  // bookkeeping that rides along each stage
  logic [`MUL_STAGES-1:0] stage_valid;
  logic [`MUL_STAGES-1:0] stage_rd_valid;
  int_op_e                stage_op       [`MUL_STAGES];
  rob_tag_t               stage_tag      [`MUL_STAGES];
  prf_index_t             stage_rd_index [`MUL_STAGES];

  assign accept   = uop_valid && (uop.fu == FU_MUL);
  assign sign_ext = (uop.op == OP_MULH);

  // stage 1, extend and split rs2 into a low unsigned and high signed half
  assign a_ext = {sign_ext & uop.rs1_data[`XLEN-1], uop.rs1_data};
  assign b_ext = {sign_ext & uop.rs2_data[`XLEN-1], uop.rs2_data};
  assign pp_lo = a_ext * $signed({1'b0, b_ext[half_w-1:0]});
  assign pp_hi = a_ext * $signed(b_ext[ext_w-1:half_w]);

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      stage_valid <= '0;
    end else begin
      stage_valid <= {stage_valid[last-1:0], accept};
    end
  end

  always_ff @(posedge clock) begin
    stage_op[0]       <= uop.op;
    stage_tag[0]      <= uop.tag;
    stage_rd_index[0] <= uop.rd_index;
    stage_rd_valid[0] <= uop.rd_valid;
    for (int i = 1; i < `MUL_STAGES; i++) begin
      stage_op[i]       <= stage_op[i-1];
      stage_tag[i]      <= stage_tag[i-1];
      stage_rd_index[i] <= stage_rd_index[i-1];
      stage_rd_valid[i] <= stage_rd_valid[i-1];
    end
    s1_pp_lo <= pp_lo;
    s1_pp_hi <= pp_hi;
    // stage 2 sum
    s2_prod  <= s1_pp_lo + (s1_pp_hi <<< half_w);
    // stage 3 word select
    s3_data  <= (stage_op[1] == OP_MUL) ? s2_prod[`XLEN-1:0] : s2_prod[2*`XLEN-1:`XLEN];
  end

  assign mul_valid  = stage_valid[last];
  assign mul_result = '{tag:      stage_tag[last],
                        rd_index: stage_rd_index[last],
                        rd_valid: stage_rd_valid[last],
                        data:     s3_data};

endmodule

`default_nettype wire

/* logic/writeback_unit.sv */
// ----------------------------------------------------------------------
// writeback merge for the integer cluster
// mul owns the port, ALU results wait in a small skid queue
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module writeback_unit import exec_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         flush,
  input  logic         alu_valid,
  input  exec_result_t alu_result,
  input  logic         mul_valid,
  input  exec_result_t mul_result,
  output logic         wb_valid,
  output exec_result_t wb,
  output logic         busy
);

  localparam int ptr_width   = (`WB_SKID_DEPTH > 1) ? $clog2(`WB_SKID_DEPTH) : 1;
  localparam int count_width = $clog2(`WB_SKID_DEPTH + 1);
  localparam logic [ptr_width-1:0] last_slot = ptr_width'(`WB_SKID_DEPTH - 1);

  exec_result_t           skid_q [`WB_SKID_DEPTH];
  logic [ptr_width-1:0]   head;
  logic [ptr_width-1:0]   tail;
  logic [count_width-1:0] count;

  logic         push;
  logic         pop;
  logic         send;
  exec_result_t send_result;

  function automatic logic [ptr_width-1:0] bump(input logic [ptr_width-1:0] ptr);
    return (ptr == last_slot) ? '0 : ptr + 1'b1;
  endfunction

  // port priority: mul, then queue head, then a fresh ALU result
  always_comb begin
    push        = 1'b0;
    pop         = 1'b0;
    send        = 1'b1;
    send_result = mul_result;
    if (mul_valid) begin
      push = alu_valid;
    end else if (count != '0) begin
      pop         = 1'b1;
      push        = alu_valid;
      send_result = skid_q[head];
    end else begin
      send        = alu_valid;
      send_result = alu_result;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= send;
      if (pop) begin
        head <= bump(head);
      end
      if (push) begin
        tail <= bump(tail);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      skid_q[tail] <= alu_result;
    end
    if (send) begin
      wb <= send_result;
    end
  end

  // one slot kept free for the ALU result already in flight
  assign busy = (count >= count_width'(`WB_SKID_DEPTH - 1));

endmodule

`default_nettype wire

/* logic/exec_cluster.sv */
// ----------------------------------------------------------------------
// integer execution cluster
// ALU and multiplier pipes merged onto one writeback port
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module exec_cluster import exec_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         flush,
  input  logic         uop_valid,
  input  issue_uop_t   uop,
  output logic         wb_valid,
  output exec_result_t wb,
  output logic         busy
);

  logic         alu_valid;
  exec_result_t alu_result;
  logic         mul_valid;
  exec_result_t mul_result;

  // both pipes see every uop and filter on fu
  alu_pipe alu_pipe_i (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .alu_valid  (alu_valid),
    .alu_result (alu_result)
  );

  mul_pipe mul_pipe_i (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .mul_valid  (mul_valid),
    .mul_result (mul_result)
  );

  writeback_unit writeback_unit_i (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .alu_valid  (alu_valid),
    .alu_result (alu_result),
    .mul_valid  (mul_valid),
    .mul_result (mul_result),
    .wb_valid   (wb_valid),
    .wb         (wb),
    .busy       (busy)
  );

endmodule

`default_nettype wire

/* bench/exec_cluster_tb.sv */
// ----------------------------------------------------------------------
// testbench for the integer execution cluster
// table of micro-ops issued in a loop, results checked by tag
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_cluster_tb import exec_pkg::*; ();

  typedef struct packed {
    fu_class_e  fu;
    int_op_e    op;
    word_t      rs1;
    word_t      rs2;
    prf_index_t rd_index;
    logic       rd_valid;
    logic       flush;
    word_t      data;
  } row_t;

  localparam int limit = 200;

  logic         clock;
  logic         reset;
  logic         flush;
  logic         uop_valid;
  issue_uop_t   uop;
  logic         wb_valid;
  exec_result_t wb;
  logic         busy;

  // row index doubles as the ROB tag
  row_t       rows[$];
  rob_tag_t   alu_order[$];
  int         seed = 32'h3bae_452d;
  int         cycle;
  int         outstanding;
  // 0 free, 1 in flight, 2 delivered, 3 flushed
  logic [1:0] state     [`ROB_SIZE];
  int         issued_at [`ROB_SIZE];

  exec_cluster dut_i (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .uop_valid (uop_valid),
    .uop       (uop),
    .wb_valid  (wb_valid),
    .wb        (wb),
    .busy      (busy)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("ERR %0t %s expected %h got %h", $time, name, expected, actual));
    end
  endtask

  task automatic check_tag(input string name, input rob_tag_t expected, input rob_tag_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("ERR %0t %s expected %0d got %0d", $time, name, expected, actual));
    end
  endtask

  task automatic check_index(input string name, input prf_index_t expected,
                             input prf_index_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("ERR %0t %s expected %0d got %0d", $time, name, expected, actual));
    end
  endtask

  // expected data straight from the RV32IM definitions
  function automatic word_t model_result(int_op_e op, word_t a, word_t b);
    logic [63:0] sprod;
    logic [63:0] uprod;
    sprod = 64'($signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b}));
    uprod = {32'b0, a} * {32'b0, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_SRL:  return a >> b[4:0];
      OP_SRA:  return word_t'($signed(a) >>> b[4:0]);
      OP_SLT:  return word_t'($signed(a) < $signed(b));
      OP_SLTU: return word_t'(a < b);
      OP_MUL:  return uprod[31:0];
      OP_MULH: return sprod[63:32];
      default: return uprod[63:32];
    endcase
  endfunction

  function automatic void add_row(fu_class_e fu, int_op_e op, word_t a, word_t b,
                                  logic fl, word_t data);
    rows.push_back('{fu: fu, op: op, rs1: a, rs2: b, rd_index: prf_index_t'(rows.size() * 5 + 1),
                     rd_valid: (rows.size() % 7 != 3), flush: fl, data: data});
  endfunction

  task automatic add_random_row(input fu_class_e fu, input logic fl);
    int_op_e op;
    word_t   a;
    word_t   b;
    if (fu == FU_ALU)
      op = int_op_e'(4'($unsigned($random(seed)) % 10));
    else
      op = int_op_e'(4'(10 + $unsigned($random(seed)) % 3));
    a = $random(seed);
    b = $random(seed);
    add_row(fu, op, a, b, fl, model_result(op, a, b));
  endtask

  task automatic build_table();
    add_row(FU_ALU, OP_ADD,  32'h0000_0007, 32'h0000_0005, 1'b0, 32'h0000_000c);
    add_row(FU_ALU, OP_SUB,  32'h0000_0003, 32'h0000_0005, 1'b0, 32'hffff_fffe);
    add_row(FU_ALU, OP_AND,  32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 32'hf000_f000);
    add_row(FU_ALU, OP_OR,   32'hf0f0_f0f0, 32'h0f0f_0000, 1'b0, 32'hffff_f0f0);
    add_row(FU_ALU, OP_XOR,  32'haaaa_5555, 32'hffff_ffff, 1'b0, 32'h5555_aaaa);
    // shift amount 0x24 only uses its low 5 bits
    add_row(FU_ALU, OP_SLL,  32'h0000_0001, 32'h0000_0024, 1'b0, 32'h0000_0010);
    add_row(FU_ALU, OP_SRL,  32'h8000_0000, 32'h0000_0004, 1'b0, 32'h0800_0000);
    add_row(FU_ALU, OP_SRA,  32'h8000_0000, 32'h0000_0004, 1'b0, 32'hf800_0000);
    add_row(FU_ALU, OP_SLT,  32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0000_0001);
    add_row(FU_ALU, OP_SLTU, 32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0000_0000);
    // mul burst on signed extremes
    add_row(FU_MUL, OP_MUL,   32'h8000_0000, 32'hffff_ffff, 1'b0, 32'h8000_0000);
    add_row(FU_MUL, OP_MULH,  32'h8000_0000, 32'h8000_0000, 1'b0, 32'h4000_0000);
    add_row(FU_MUL, OP_MULH,  32'h7fff_ffff, 32'h8000_0000, 1'b0, 32'hc000_0000);
    add_row(FU_MUL, OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 1'b0, 32'hffff_fffe);
    add_row(FU_MUL, OP_MULH,  32'hffff_ffff, 32'hffff_ffff, 1'b0, 32'h0000_0000);
    // ALU burst right behind it fills the skid queue
    repeat (5) add_random_row(FU_ALU, 1'b0);
    // mixed stream, each mul lands on the port with an ALU result
    for (int k = 0; k < 6; k++) begin
      add_random_row((k % 3 == 0) ? FU_MUL : FU_ALU, 1'b0);
    end
    // work in flight, flush on the last of these four
    add_random_row(FU_MUL, 1'b0);
    add_random_row(FU_MUL, 1'b0);
    add_random_row(FU_ALU, 1'b0);
    add_random_row(FU_MUL, 1'b1);
    add_random_row(FU_ALU, 1'b0);
    add_random_row(FU_MUL, 1'b0);
  endtask

  task automatic issue_row(input int i);
    rob_tag_t t;
    t = rob_tag_t'(i);
    uop = '{fu: rows[i].fu, op: rows[i].op, tag: t, rd_index: rows[i].rd_index,
            rd_valid: rows[i].rd_valid, rs1_data: rows[i].rs1, rs2_data: rows[i].rs2};
    uop_valid    = 1'b1;
    flush        = rows[i].flush;
    state[t]     = 2'd1;
    issued_at[t] = cycle;
    outstanding++;
    if (rows[i].fu == FU_ALU) alu_order.push_back(t);
  endtask

  // everything still in flight is gone after the flush edge
  task automatic flush_scoreboard();
    for (int t = 0; t < `ROB_SIZE; t++) begin
      if (state[t] == 2'd1) state[t] = 2'd3;
    end
    alu_order.delete();
    outstanding = 0;
  endtask

  task automatic check_result();
    rob_tag_t t;
    t = wb.tag;
    if (state[t] == 2'd0) stop_run($sformatf("result for tag %0d that was never issued", t));
    if (state[t] == 2'd2) stop_run($sformatf("tag %0d was delivered a second time", t));
    if (state[t] == 2'd3) stop_run($sformatf("result for tag %0d that was flushed", t));
    check_word("wb.data", rows[t].data, wb.data);
    check_index("wb.rd_index", rows[t].rd_index, wb.rd_index);
    if (wb.rd_valid !== rows[t].rd_valid) begin
      stop_run($sformatf("ERR %0t wb.rd_valid expected %b got %b", $time,
                         rows[t].rd_valid, wb.rd_valid));
    end
    if (rows[t].fu == FU_MUL) begin
      if (cycle - issued_at[t] != 4) begin
        stop_run($sformatf("mul tag %0d took %0d cycles, not 4", t, cycle - issued_at[t]));
      end
    end else begin
      if (alu_order.size() == 0) stop_run("ALU result with no ALU micro-op pending");
      check_tag("wb.tag", alu_order.pop_front(), t);
    end
    state[t] = 2'd2;
    outstanding--;
  endtask

  // outputs are stable mid-cycle
  always @(negedge clock) begin
    if (!reset && wb_valid === 1'b1) check_result();
  end

  initial begin
    int stalls;
    int waited;
    reset     = 1'b1;
    flush     = 1'b0;
    uop_valid = 1'b0;
    uop       = '0;
    stalls    = 0;
    for (int t = 0; t < `ROB_SIZE; t++) state[t] = 2'd0;
    build_table();
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    if (wb_valid !== 1'b0 || busy !== 1'b0) stop_run("wb_valid or busy not low after reset");
    for (int i = 0; i < rows.size(); i++) begin
      waited = 0;
      while (rows[i].fu == FU_ALU && busy) begin
        waited++;
        stalls++;
        if (waited > limit) stop_run("busy stayed high, ALU issue blocked too long");
        @(posedge clock);
        #1;
      end
      issue_row(i);
      @(posedge clock);
      #1;
      uop_valid = 1'b0;
      flush     = 1'b0;
      if (rows[i].flush) flush_scoreboard();
    end
    waited = 0;
    while (outstanding != 0 && waited < limit) begin
      waited++;
      @(posedge clock);
    end
    // idle window for any late flushed result
    repeat (20) @(posedge clock);
    if (stalls == 0) stop_run("busy never rose, ALU issue was never held");
    if (outstanding != 0) begin
      stop_run($sformatf("%0d results missing after the drain", outstanding));
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/exec_pkg.sv
logic/alu_pipe.sv
logic/mul_pipe.sv
logic/writeback_unit.sv
logic/exec_cluster.sv
bench/exec_cluster_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the cluster testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module exec_cluster_tb -f list.f -o sim_exec \
  && ./obj_dir/sim_exec | tee /dev/stderr | grep -F '** PASS **' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
